//--- source/fpu_consts.svh
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// =====================================================================
// Data widths, single precision only
// =====================================================================
`define FPU_FLEN 32                  // Float register width
`define FPU_XLEN 32                  // Integer register width

// IEEE 754 binary32 patterns
`define FPU_CANON_NAN 32'h7fc00000   // Canonical quiet NaN, positive
`define FPU_EXP_ONES 8'hff           // Exponent of inf and NaN

// =====================================================================
// funct3 codes for FP_CMP
// =====================================================================
`define FPU_F3_FEQ 3'd2
`define FPU_F3_FLT 3'd1
`define FPU_F3_FLE 3'd0

// FCLASS result mask, one bit per category
`define FPU_CLASS_BITS 10

`endif

//--- source/fpu_pkg.sv
`include "fpu_consts.svh"

package fpu_pkg;

  // fp_alu_op encoding as sent by the control unit
  typedef enum logic [4:0] {
    FP_ADD    = 5'b00000,
    FP_SUB    = 5'b00001,
    FP_MUL    = 5'b00010,
    FP_DIV    = 5'b00011,
    FP_SQRT   = 5'b00100,
    FP_SGNJ   = 5'b00101,
    FP_SGNJN  = 5'b00110,
    FP_SGNJX  = 5'b00111,
    FP_MIN    = 5'b01000,
    FP_MAX    = 5'b01001,
    FP_CVT    = 5'b01010,
    FP_CMP    = 5'b01011,
    FP_CLASS  = 5'b01100,
    FP_FMA    = 5'b01101,
    FP_FMSUB  = 5'b01110,
    FP_FNMSUB = 5'b01111,
    FP_FNMADD = 5'b10000,
    FP_MV_XW  = 5'b10001,  // Float bits to integer register
    FP_MV_WX  = 5'b10010   // Integer bits to float register
  } fp_op_e;

  // Internal operation after decode, compares already split by funct3
  typedef enum logic [3:0] {
    SGNJ, SGNJN, SGNJX, MIN, MAX, FEQ, FLT, FLE, CLASS, MV_XW, MV_WX, UNSUPPORTED
  } unit_op_e;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;  // Biased by 127
    logic [22:0] mantissa;  // Fraction without hidden bit
  } fp_fields_t;

  // Same 32 bits, seen as a plain word or as IEEE fields
  typedef union packed {
    logic [`FPU_FLEN-1:0] raw;
    fp_fields_t           fields;
  } fp32_word_u;

  typedef struct packed {
    logic is_neg;
    logic is_inf;
    logic is_zero;
    logic is_sub;
    logic is_norm;
    logic is_snan;
    logic is_qnan;
  } fp_class_t;

endpackage

//--- source/fpu_op_if.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

// One decoded operation, qualified by valid, no ready
interface fpu_op_if;
  import fpu_pkg::*;

  logic                 valid;        // One operation per high cycle
  unit_op_e             op;           // Decoded operation
  fp32_word_u           a;            // rs1 float operand
  fp32_word_u           b;            // rs2 float operand
  logic [`FPU_XLEN-1:0] int_operand;  // Source of FMV.W.X

  // Input side drives
  modport issue (
    output valid, op, a, b, int_operand
  );

  // Processing side reads
  modport compute (
    input valid, op, a, b, int_operand
  );

endinterface

//--- source/fpu_res_if.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

// One finished result, qualified by valid, no ready
interface fpu_res_if;
  import fpu_pkg::*;

  logic                 valid;       // Result present this cycle
  fp32_word_u           fp_result;   // Float destination value
  logic [`FPU_XLEN-1:0] int_result;  // Integer destination value
  logic                 nv;          // Invalid operation

  modport produce (
    output valid, fp_result, int_result, nv
  );

  modport consume (
    input valid, fp_result, int_result, nv
  );

endinterface

//--- source/fpu_issue.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_issue (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,        // New operation this cycle
  input  fpu_pkg::fp_op_e      fp_alu_op,
  input  logic [2:0]           funct3,       // Compare select for FP_CMP
  input  logic [`FPU_FLEN-1:0] operand_a,
  input  logic [`FPU_FLEN-1:0] operand_b,
  input  logic [`FPU_XLEN-1:0] int_operand,
  fpu_op_if.issue              op
);
  import fpu_pkg::*;

  unit_op_e dec_op;  // Decoded from fp_alu_op and funct3

  // =====================================================================
  // Decode
  // =====================================================================
  always_comb begin
    case (fp_alu_op)
      FP_SGNJ:  dec_op = SGNJ;
      FP_SGNJN: dec_op = SGNJN;
      FP_SGNJX: dec_op = SGNJX;
      FP_MIN:   dec_op = MIN;
      FP_MAX:   dec_op = MAX;
      FP_CMP: begin
        case (funct3)
          `FPU_F3_FLT: dec_op = FLT;
          `FPU_F3_FLE: dec_op = FLE;
          default:     dec_op = FEQ;  // FEQ code and all spare codes
        endcase
      end
      FP_CLASS: dec_op = CLASS;
      FP_MV_XW: dec_op = MV_XW;
      FP_MV_WX: dec_op = MV_WX;
      // Arithmetic, FMA and converters are not built here
      default:  dec_op = UNSUPPORTED;
    endcase
  end

  // =====================================================================
  // Issue register
  // =====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= start;  // One cycle of valid per start
    end
  end

  // Payload only moves with a new operation
  always_ff @(posedge clk) begin
    if (start) begin
      op.op          <= dec_op;
      op.a.raw       <= operand_a;
      op.b.raw       <= operand_b;
      op.int_operand <= int_operand;
    end
  end

endmodule

//--- source/fp_operand_class.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fp_operand_class (
  input  fpu_pkg::fp32_word_u word,  // Value under test
  output fpu_pkg::fp_class_t  cls    // Exactly one category set, plus sign
);
  import fpu_pkg::*;

  logic exp_ones;   // Exponent all ones, inf or NaN
  logic exp_zero;   // Exponent all zeros, zero or subnormal
  logic man_zero;   // No fraction bits set
  logic quiet_bit;  // Top fraction bit, quiet NaN marker

  assign exp_ones  = (word.fields.exponent == `FPU_EXP_ONES);
  assign exp_zero  = (word.fields.exponent == 8'h00);
  assign man_zero  = (word.fields.mantissa == 23'h0);
  assign quiet_bit = word.fields.mantissa[22];

  // =====================================================================
  // Category
  // =====================================================================
  always_comb begin
    cls.is_neg = word.fields.sign;  // Reported for NaN too

    // Special exponent
    cls.is_inf  = exp_ones && man_zero;
    cls.is_snan = exp_ones && !man_zero && !quiet_bit;
    cls.is_qnan = exp_ones && quiet_bit;

    // Zero exponent
    cls.is_zero = exp_zero && man_zero;
    cls.is_sub  = exp_zero && !man_zero;  // Denormal, no hidden bit

    // Everything in between
    cls.is_norm = !exp_ones && !exp_zero;
  end

endmodule

//--- source/fpu_compute.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_compute (
  input  logic       clk,
  input  logic       rst_n,
  fpu_op_if.compute  op,
  fpu_res_if.produce res
);
  import fpu_pkg::*;

  fp_class_t                  cls_a;       // Category of rs1
  fp_class_t                  cls_b;       // Category of rs2
  logic                       a_nan;
  logic                       b_nan;
  logic                       any_nan;
  logic                       any_snan;
  logic                       both_zero;   // Zeros of any sign
  logic                       mag_lt;      // |a| < |b|
  logic                       mag_gt;      // |a| > |b|
  logic                       ord_lt;      // a < b, -0 equal to +0
  logic                       ord_eq;      // a == b, -0 equal to +0
  logic                       mm_lt;       // a < b, -0 below +0
  logic [`FPU_CLASS_BITS-1:0] class_mask;  // FCLASS of rs1
  fp32_word_u                 minmax_val;
  fp32_word_u                 fp_next;
  logic [`FPU_XLEN-1:0]       int_next;
  logic                       nv_next;

  fp_operand_class u_class_a (.word(op.a), .cls(cls_a));
  fp_operand_class u_class_b (.word(op.b), .cls(cls_b));

  // =====================================================================
  // Ordering
  // =====================================================================
  assign a_nan     = cls_a.is_snan | cls_a.is_qnan;
  assign b_nan     = cls_b.is_snan | cls_b.is_qnan;
  assign any_nan   = a_nan | b_nan;
  assign any_snan  = cls_a.is_snan | cls_b.is_snan;
  assign both_zero = cls_a.is_zero & cls_b.is_zero;

  // Magnitude order is plain unsigned order of exponent and fraction
  assign mag_lt = {op.a.fields.exponent, op.a.fields.mantissa} <
                  {op.b.fields.exponent, op.b.fields.mantissa};
  assign mag_gt = {op.a.fields.exponent, op.a.fields.mantissa} >
                  {op.b.fields.exponent, op.b.fields.mantissa};

  always_comb begin
    if (op.a.fields.sign != op.b.fields.sign) begin
      ord_lt = op.a.fields.sign && !both_zero;  // Negative side is lower
    end else if (op.a.fields.sign) begin
      ord_lt = mag_gt;                          // Both negative, order flips
    end else begin
      ord_lt = mag_lt;
    end
  end

  assign ord_eq = (op.a.raw == op.b.raw) || both_zero;
  assign mm_lt  = ord_lt || (both_zero && op.a.fields.sign && !op.b.fields.sign);

  // =====================================================================
  // FMIN / FMAX
  // =====================================================================
  always_comb begin
    if (a_nan && b_nan) begin
      minmax_val.raw = `FPU_CANON_NAN;
    end else if (a_nan) begin
      minmax_val = op.b;  // NaN loses to a number
    end else if (b_nan) begin
      minmax_val = op.a;
    end else if (op.op == MAX) begin
      minmax_val = mm_lt ? op.b : op.a;
    end else begin
      minmax_val = mm_lt ? op.a : op.b;
    end
  end

  // FCLASS mask, bit 0 is -inf up to bit 9 quiet NaN
  assign class_mask = {cls_a.is_qnan,
                       cls_a.is_snan,
                       !cls_a.is_neg & cls_a.is_inf,
                       !cls_a.is_neg & cls_a.is_norm,
                       !cls_a.is_neg & cls_a.is_sub,
                       !cls_a.is_neg & cls_a.is_zero,
                       cls_a.is_neg & cls_a.is_zero,
                       cls_a.is_neg & cls_a.is_sub,
                       cls_a.is_neg & cls_a.is_norm,
                       cls_a.is_neg & cls_a.is_inf};

  // =====================================================================
  // Result select, unused result stays zero
  // =====================================================================
  always_comb begin
    fp_next  = '0;
    int_next = '0;
    nv_next  = 1'b0;
    case (op.op)
      SGNJ:  fp_next.raw = {op.b.fields.sign, op.a.raw[`FPU_FLEN-2:0]};
      SGNJN: fp_next.raw = {!op.b.fields.sign, op.a.raw[`FPU_FLEN-2:0]};
      SGNJX: fp_next.raw = {op.a.fields.sign ^ op.b.fields.sign, op.a.raw[`FPU_FLEN-2:0]};
      MIN, MAX: begin
        fp_next = minmax_val;
        nv_next = any_snan;  // Quiet NaN input is not invalid
      end
      FEQ: begin
        int_next = {{(`FPU_XLEN-1){1'b0}}, ord_eq && !any_nan};
        nv_next  = any_snan;
      end
      FLT: begin
        int_next = {{(`FPU_XLEN-1){1'b0}}, ord_lt && !any_nan};
        nv_next  = any_nan;  // Signalling compare
      end
      FLE: begin
        int_next = {{(`FPU_XLEN-1){1'b0}}, (ord_lt || ord_eq) && !any_nan};
        nv_next  = any_nan;
      end
      CLASS: int_next = {{(`FPU_XLEN-`FPU_CLASS_BITS){1'b0}}, class_mask};
      MV_XW: int_next = op.a.raw;         // Bit copy, no conversion
      MV_WX: fp_next.raw = op.int_operand;
      default: ;                           // UNSUPPORTED, all zero
    endcase
  end

  // =====================================================================
  // Result register
  // =====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= op.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op.valid) begin
      res.fp_result  <= fp_next;
      res.int_result <= int_next;
      res.nv         <= nv_next;
    end
  end

endmodule

//--- source/fpu_retire.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_retire (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clear_flags,  // Clears the accumulated flag
  fpu_res_if.consume           res,
  output logic                 done,         // One cycle per result
  output logic [`FPU_FLEN-1:0] fp_result,
  output logic [`FPU_XLEN-1:0] int_result,
  output logic                 flag_nv,      // Flag of this result
  output logic                 nv_sticky     // Accumulated, like fflags.NV
);

  // =====================================================================
  // Output registers, hold while idle
  // =====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done       <= 1'b0;
      fp_result  <= '0;
      int_result <= '0;
      flag_nv    <= 1'b0;
    end else begin
      done <= res.valid;
      if (res.valid) begin
        fp_result  <= res.fp_result.raw;
        int_result <= res.int_result;
        flag_nv    <= res.nv;
      end
    end
  end

  // Set has priority over clear at the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nv_sticky <= 1'b0;
    end else if (res.valid && res.nv) begin
      nv_sticky <= 1'b1;
    end else if (clear_flags) begin
      nv_sticky <= 1'b0;
    end
  end

endmodule

//--- source/fpu_top.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,        // Sampled every cycle, no stall
  input  fpu_pkg::fp_op_e      fp_alu_op,
  input  logic [2:0]           funct3,
  input  logic [`FPU_FLEN-1:0] operand_a,
  input  logic [`FPU_FLEN-1:0] operand_b,
  input  logic [`FPU_XLEN-1:0] int_operand,
  input  logic                 clear_flags,
  output logic                 done,         // Third cycle after start
  output logic [`FPU_FLEN-1:0] fp_result,
  output logic [`FPU_XLEN-1:0] int_result,
  output logic                 flag_nv,
  output logic                 nv_sticky
);

  // =====================================================================
  // Stage links
  // =====================================================================
  fpu_op_if  op_bus ();   // Issue to compute
  fpu_res_if res_bus ();  // Compute to retire

  fpu_issue u_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .fp_alu_op   (fp_alu_op),
    .funct3      (funct3),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .int_operand (int_operand),
    .op          (op_bus.issue)
  );

  fpu_compute u_compute (
    .clk   (clk),
    .rst_n (rst_n),
    .op    (op_bus.compute),
    .res   (res_bus.produce)
  );

  fpu_retire u_retire (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_flags (clear_flags),
    .res         (res_bus.consume),
    .done        (done),
    .fp_result   (fp_result),
    .int_result  (int_result),
    .flag_nv     (flag_nv),
    .nv_sticky   (nv_sticky)
  );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

// Free running clock and power-on reset for the testbench
module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 10;  // 20 ns period

  initial clk = 1'b0;
  always #HALF_PERIOD clk = ~clk;

  initial begin
    rst_n = 1'b0;                 // Asserted from time zero
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;                // Released after two reset edges
  end

endmodule

//--- bench/fpu_tb.sv
`timescale 1ns/1ns
`include "fpu_consts.svh"

module fpu_tb;
  import fpu_pkg::*;

  localparam int N_MOVE   = 60;   // Sign injection and moves
  localparam int N_MINMAX = 80;
  localparam int N_CMP    = 100;
  localparam int N_CLASS  = 60;
  localparam int N_BURST  = 300;  // Start held high, all op codes
  localparam int N_STICKY = 7;
  localparam int N_TOTAL  = N_MOVE + N_MINMAX + N_CMP + N_CLASS + N_BURST + N_STICKY;
  localparam int LIMIT    = 4 * N_TOTAL + 100;  // Cycle budget for the whole run

  logic        clk, rst_n, start, clear_flags, done, flag_nv, nv_sticky;
  fp_op_e      fp_alu_op;
  logic [2:0]  funct3;
  logic [31:0] operand_a, operand_b, int_operand, fp_result, int_result;

  logic [31:0] lfsr = 32'd70117;  // Random state
  int          cycle = 0;
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  int          retired = 0;
  int          checks_at_test = 0;
  int          errors_at_test = 0;

  // Expected results in issue order
  string       name_q[$];
  fp32_word_u  fp_q[$];
  logic [31:0] int_q[$];
  logic        nv_q[$];
  int          due_q[$];  // Cycle in which done must show

  // Output model between results
  fp32_word_u  last_fp = '0;
  logic [31:0] last_int = '0;
  logic        last_nv = 1'b0;
  logic        sticky_model = 1'b0;
  logic        clear_prev = 1'b0;  // clear_flags as sampled at the coming edge

  tb_clock u_clock (.clk(clk), .rst_n(rst_n));
  fpu_top  DUT (.*);

  // =====================================================================
  // Random numbers and operand pool
  // =====================================================================
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // Galois step
    end
    return r;
  endfunction

  function automatic fp32_word_u pick_operand();
    fp32_word_u w;
    w.raw = rand_bits(32);  // Sign and fill for every category
    case (rand_bits(3))
      0: w.raw[30:0] = '0;                       // Signed zero
      1: w.raw[30:0] = {`FPU_EXP_ONES, 23'h0};   // Infinity
      2: w.raw[30:23] = 8'h00;                   // Subnormal, or zero if fraction empty
      3: w.raw[30:22] = {`FPU_EXP_ONES, 1'b1};   // Quiet NaN
      4: begin
        w.raw[30:22] = {`FPU_EXP_ONES, 1'b0};    // Signalling NaN
        w.raw[0]     = 1'b1;                     // Keep it off infinity
      end
      5: w.raw = `FPU_CANON_NAN;
      default: ;                                 // Plain random word
    endcase
    return w;
  endfunction

  // =====================================================================
  // Reference model
  // =====================================================================
  function automatic logic is_nan(input fp32_word_u w);
    return (w.fields.exponent == `FPU_EXP_ONES) && (w.fields.mantissa != 0);
  endfunction

  function automatic logic is_snan(input fp32_word_u w);
    return is_nan(w) && !w.fields.mantissa[22];
  endfunction

  // Signed number line position, both zeros land on 0
  function automatic logic signed [32:0] order_key(input fp32_word_u w);
    logic signed [32:0] mag;
    mag = {2'b00, w.raw[30:0]};
    return w.raw[31] ? -mag : mag;
  endfunction

  function automatic logic [31:0] class_mask_of(input fp32_word_u w);
    int bit_idx;
    if (is_nan(w)) bit_idx = is_snan(w) ? 8 : 9;
    else if (w.fields.exponent == `FPU_EXP_ONES) bit_idx = w.fields.sign ? 0 : 7;
    else if (w.raw[30:0] == 0) bit_idx = w.fields.sign ? 3 : 4;
    else if (w.fields.exponent == 8'h00) bit_idx = w.fields.sign ? 2 : 5;
    else bit_idx = w.fields.sign ? 1 : 6;
    return 32'd1 << bit_idx;
  endfunction

  task automatic model_op(input fp_op_e o, input logic [2:0] f3, input fp32_word_u a,
                          input fp32_word_u b, input logic [31:0] iop,
                          output fp32_word_u fp, output logic [31:0] ir, output logic nv);
    logic a_less;
    logic any_nan;
    fp      = '0;
    ir      = '0;
    nv      = 1'b0;
    any_nan = is_nan(a) || is_nan(b);
    a_less  = (order_key(a) < order_key(b)) || (a.raw == 32'h80000000 && b.raw == 32'h0);
    case (o)
      FP_SGNJ:  fp.raw = {b.raw[31], a.raw[30:0]};
      FP_SGNJN: fp.raw = {~b.raw[31], a.raw[30:0]};
      FP_SGNJX: fp.raw = {a.raw[31] ^ b.raw[31], a.raw[30:0]};
      FP_MIN, FP_MAX: begin
        if (is_nan(a) && is_nan(b)) fp.raw = `FPU_CANON_NAN;
        else if (is_nan(a)) fp = b;
        else if (is_nan(b)) fp = a;
        else fp = (a_less == (o == FP_MIN)) ? a : b;  // -0 below +0
        nv = is_snan(a) || is_snan(b);
      end
      FP_CMP: begin
        if (f3 == `FPU_F3_FLT) begin
          ir = {31'h0, order_key(a) < order_key(b)};
          nv = any_nan;
        end else if (f3 == `FPU_F3_FLE) begin
          ir = {31'h0, order_key(a) <= order_key(b)};
          nv = any_nan;
        end else begin
          ir = {31'h0, order_key(a) == order_key(b)};  // FEQ, spare codes too
          nv = is_snan(a) || is_snan(b);
        end
        if (any_nan) ir = '0;                         // Unordered is false
      end
      FP_CLASS: ir = class_mask_of(a);
      FP_MV_XW: ir = a.raw;
      FP_MV_WX: fp.raw = iop;
      default: ;                                      // Dropped units, all zero
    endcase
  endtask

  // =====================================================================
  // Compare tasks
  // =====================================================================
  task automatic check_word(input string name, input string what,
                            input fp32_word_u exp, input fp32_word_u act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp.raw, act.raw);
    end
  endtask

  task automatic check_int(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input string what,
                            input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", name, what, exp, act);
    end
  endtask

  // =====================================================================
  // Stimulus tasks
  // =====================================================================
  task automatic issue_op(input string name, input fp_op_e o, input logic [2:0] f3,
                          input fp32_word_u a, input fp32_word_u b, input logic [31:0] iop);
    fp32_word_u  efp;
    logic [31:0] eint;
    logic        env;
    @(posedge clk);
    start       <= 1'b1;
    fp_alu_op   <= o;
    funct3      <= f3;
    operand_a   <= a.raw;
    operand_b   <= b.raw;
    int_operand <= iop;
    model_op(o, f3, a, b, iop, efp, eint, env);
    name_q.push_back(name);
    fp_q.push_back(efp);
    int_q.push_back(eint);
    nv_q.push_back(env);
    due_q.push_back(cycle + 4);  // Sampled next edge, done two edges later
  endtask

  task automatic gap();
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    start       <= 1'b0;
    clear_flags <= 1'b1;
    @(posedge clk);
    clear_flags <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    @(posedge clk);
    start       <= 1'b0;
    clear_flags <= 1'b0;
    while (name_q.size() != 0) @(posedge clk);  // Drain, timeout guards a lost done
    tests++;
    $display("Test %-7s finished: %0d checks, %0d errors", name,
             checks - checks_at_test, errors - errors_at_test);
    checks_at_test = checks;
    errors_at_test = errors;
  endtask

  // =====================================================================
  // Result monitor, samples at the falling edge
  // =====================================================================
  always @(negedge clk) begin : monitor
    logic exp_nv;
    exp_nv = 1'b0;
    if (rst_n) begin
      if (done && name_q.size() == 0) begin
        errors++;
        $display("Error: done pulsed at cycle %0d with no operation outstanding", cycle);
        last_fp  = fp_result;
        last_int = int_result;
        last_nv  = flag_nv;
      end else if (done) begin
        exp_nv   = nv_q.pop_front();
        last_fp  = fp_q.pop_front();
        last_int = int_q.pop_front();
        last_nv  = exp_nv;
        check_word(name_q[0], "fp_result", last_fp, fp_result);
        check_int(name_q[0], "int_result", last_int, int_result);
        check_flag(name_q[0], "flag_nv", exp_nv, flag_nv);
        check_int(name_q[0], "done cycle", due_q.pop_front(), cycle);
        void'(name_q.pop_front());
        retired++;
      end else begin
        check_word("idle", "fp_result held", last_fp, fp_result);
        check_int("idle", "int_result held", last_int, int_result);
        check_flag("idle", "flag_nv held", last_nv, flag_nv);
      end
      if (done && exp_nv) sticky_model = 1'b1;  // New flag beats clear
      else if (clear_prev) sticky_model = 1'b0;
      check_flag("sticky", "nv_sticky", sticky_model, nv_sticky);
      clear_prev = clear_flags;
    end
  end

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= LIMIT) begin
      $display("Timeout: run reached %0d cycles with %0d results still outstanding",
               LIMIT, name_q.size());
      $display("Test failed");
      $finish;
    end
  end

  // =====================================================================
  // Test sequence
  // =====================================================================
  initial begin : stimulus
    fp_op_e      move_ops[5] = '{FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MV_XW, FP_MV_WX};
    fp_op_e      o;
    fp32_word_u  a, b;
    logic [2:0]  f3;
    logic [31:0] iop;
    start       = 1'b0;
    clear_flags = 1'b0;
    fp_alu_op   = FP_ADD;
    funct3      = 3'd0;
    operand_a   = '0;
    operand_b   = '0;
    int_operand = '0;
    wait (rst_n === 1'b1);

    for (int i = 0; i < N_MOVE; i++) begin
      o     = move_ops[rand_bits(3) % 5];
      a.raw = rand_bits(32);
      b.raw = rand_bits(32);
      iop   = rand_bits(32);
      issue_op($sformatf("move #%0d", i), o, 3'd0, a, b, iop);
      if (rand_bits(1)) gap();
    end
    finish_test("move");

    for (int i = 0; i < N_MINMAX; i++) begin
      o = rand_bits(1) ? FP_MAX : FP_MIN;
      a = pick_operand();
      b = pick_operand();
      if (rand_bits(2) == 0) b.raw = a.raw ^ (rand_bits(1) << 31);  // Same magnitude, any sign
      issue_op($sformatf("minmax #%0d", i), o, 3'd0, a, b, '0);
      if (rand_bits(1)) gap();
    end
    finish_test("minmax");

    for (int i = 0; i < N_CMP; i++) begin
      f3 = 3'(rand_bits(3));  // Codes 3 to 7 act as FEQ
      a  = pick_operand();
      b  = pick_operand();
      if (rand_bits(2) == 0) b.raw = a.raw ^ (rand_bits(1) << 31);
      issue_op($sformatf("cmp #%0d", i), FP_CMP, f3, a, b, '0);
      if (rand_bits(1)) gap();
    end
    finish_test("cmp");

    for (int i = 0; i < N_CLASS; i++) begin
      a = pick_operand();
      issue_op($sformatf("class #%0d", i), FP_CLASS, 3'd0, a, '0, '0);
      if (rand_bits(1)) gap();
    end
    finish_test("class");

    // Back to back, every op code, random flag clears
    for (int i = 0; i < N_BURST; i++) begin
      o   = fp_op_e'(rand_bits(5) % 19);
      f3  = 3'(rand_bits(3));
      a   = pick_operand();
      b   = pick_operand();
      iop = rand_bits(32);
      issue_op($sformatf("burst #%0d", i), o, f3, a, b, iop);
      clear_flags <= (rand_bits(3) == 0);
    end
    finish_test("burst");

    // Set, hold through clean results, clear, then set and clear on one edge
    pulse_clear();
    issue_op("sticky #0", FP_CMP, `FPU_F3_FLT, `FPU_CANON_NAN, 32'h3f800000, '0);
    for (int i = 1; i <= 3; i++) begin
      issue_op($sformatf("sticky #%0d", i), FP_SGNJ, 3'd0, 32'h3f800000, 32'h0, '0);
    end
    pulse_clear();
    issue_op("sticky #4", FP_CMP, `FPU_F3_FLE, 32'h3f800000, `FPU_CANON_NAN, '0);
    gap();
    pulse_clear();  // Clear sampled on the done edge of sticky #4
    issue_op("sticky #5", FP_SGNJN, 3'd0, 32'h40000000, 32'h0, '0);
    issue_op("sticky #6", FP_MV_WX, 3'd0, '0, '0, 32'h12345678);
    finish_test("sticky");

    $display("Summary: %0d tests, %0d of %0d results, %0d checks, %0d errors",
             tests, retired, N_TOTAL, checks, errors);
    if (errors == 0 && retired == N_TOTAL) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+source
source/fpu_pkg.sv
source/fpu_op_if.sv
source/fpu_res_if.sv
source/fpu_issue.sv
source/fp_operand_class.sv
source/fpu_compute.sv
source/fpu_retire.sv
source/fpu_top.sv
bench/tb_clock.sv
bench/fpu_tb.sv

//--- Bender.yml
package:
  name: fpu_single_cycle

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fpu_pkg.sv
      - source/fpu_op_if.sv
      - source/fpu_res_if.sv
      - source/fpu_issue.sv
      - source/fp_operand_class.sv
      - source/fpu_compute.sv
      - source/fpu_retire.sv
      - source/fpu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_clock.sv
      - bench/fpu_tb.sv
